// File: adcReclock.sv
`timescale 1ns/1ps
`include "stcDemod_cfg.svh"

module adcReclock import stcDemodPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  adcWord_t adc,
    output sample_t  adcSample
);

    adcWord_t adcReg;       // Pad register stage

    //*********************************************************************
    // Reclock and convert
    //*********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            adcReg    <= '0;
            adcSample <= '0;
        end else begin
            adcReg <= adc;
            // Offset binary to two's complement, left justified
            adcSample <= sample_t'({
                ~adcReg[`ADC_W-1],
                adcReg[`ADC_W-2:0],
                {(`SAMPLE_W-`ADC_W){1'b0}}
            });
        end
    end

endmodule

// File: bitSync.sv
`timescale 1ns/1ps
`include "stcDemod_cfg.svh"

module bitSync import stcDemodPkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  clocksPerBit_t clocksPerBit,
    input  sample_t       adcSample,
    output logic          bitValue,
    output logic          chClkOut,
    output logic          chDataOut
);

    clocksPerBit_t effCpb;      // Clamped to at least 2
    clocksPerBit_t cnt;         // Cycles left in this period
    clocksPerBit_t lowCount;    // floor(period/2), clock low cycles
    logic          bitEn;
    logic          dataBit;

    assign effCpb = (clocksPerBit < clocksPerBit_t'(2)) ? clocksPerBit_t'(2) : clocksPerBit;
    assign bitEn  = (cnt <= clocksPerBit_t'(1));

    //*********************************************************************
    // Period counter
    //*********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt      <= '0;             // Wraps on the first edge
            lowCount <= '0;
            chClkOut <= 1'b0;
            dataBit  <= 1'b0;
        end else if (bitEn) begin
            // New period, rate change lands here
            cnt      <= effCpb;
            lowCount <= effCpb >> 1;
            chClkOut <= 1'b1;
            dataBit  <= ~adcSample[`SAMPLE_W-1];   // Sign slicer
        end else begin
            cnt      <= cnt - 1'b1;
            // High for the first ceil(period/2) cycles
            chClkOut <= (cnt - 1'b1) > lowCount;
        end
    end

    assign bitValue  = dataBit;     // To DAC source mux
    assign chDataOut = dataBit;     // Pin

endmodule

// File: controlRegs.sv
`timescale 1ns/1ps
`include "stcDemod_cfg.svh"

module controlRegs import stcDemodPkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          regWr,
    input  regAddr_t      regAddr,
    input  regData_t      regWrData,
    input  byteEn_t       regByteEn,
    output regData_t      regRdData,
    output clocksPerBit_t clocksPerBit,
    output dacSource_t    dac0Source,
    output dacSource_t    dac1Source
);

    regData_t      scratch;
    clocksPerBit_t cpbReg;
    logic [1:0]    dac0Sel;     // DAC select bits 1:0
    logic [1:0]    dac1Sel;     // DAC select bits 5:4

    // Replace only the enabled byte lanes
    function automatic regData_t mergeBytes(
        regData_t oldVal,
        regData_t newVal,
        byteEn_t  en
    );
        regData_t result;
        result = oldVal;
        for (int i = 0; i < $bits(byteEn_t); i++) begin
            if (en[i]) begin
                result[8*i +: 8] = newVal[8*i +: 8];
            end
        end
        return result;
    endfunction

    //*********************************************************************
    // Register writes
    //*********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            scratch <= '0;
            cpbReg  <= clocksPerBit_t'(`CPB_RESET);
            dac0Sel <= 2'b00;
            dac1Sel <= 2'b00;
        end else if (regWr) begin
            case (regAddr)
                `SCRATCH_ADDR: begin
                    scratch <= mergeBytes(scratch, regWrData, regByteEn);
                end
                `CLOCKS_PER_BIT_ADDR: begin
                    cpbReg <= clocksPerBit_t'(
                        mergeBytes(regData_t'(cpbReg), regWrData, regByteEn));
                end
                `DAC_SELECT_ADDR: begin
                    if (regByteEn[0]) begin
                        dac0Sel <= regWrData[1:0];
                        dac1Sel <= regWrData[5:4];
                    end
                end
                default: ;      // Version and unmapped addresses
            endcase
        end
    end

    // Read data mux
    always_comb begin
        case (regAddr)
            `VERSION_ADDR:        regRdData = regData_t'(`VER_NUMBER);
            `SCRATCH_ADDR:        regRdData = scratch;
            `CLOCKS_PER_BIT_ADDR: regRdData = regData_t'(cpbReg);
            `DAC_SELECT_ADDR:     regRdData = regData_t'({dac1Sel, 2'b00, dac0Sel});
            default:              regRdData = '0;
        endcase
    end

    assign clocksPerBit = cpbReg;
    assign dac0Source   = dacSource_t'(dac0Sel);
    assign dac1Source   = dacSource_t'(dac1Sel);

endmodule

// File: dacOutput.sv
`timescale 1ns/1ps
`include "stcDemod_cfg.svh"

module dacOutput import stcDemodPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  dacSource_t dacSource,
    input  sample_t    adcSample,
    input  logic       bitValue,
    output adcWord_t   dacData
);

    // Full scale levels for the bit source
    localparam sample_t BIT_HIGH = {1'b0, {(`SAMPLE_W-1){1'b1}}};
    localparam sample_t BIT_LOW  = {1'b1, {(`SAMPLE_W-1){1'b0}}};

    sample_t srcReg;

    //*********************************************************************
    // Source select and output format
    //*********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            srcReg  <= '0;
            dacData <= '0;
        end else begin
            case (dacSource)
                dacSrcAdc: begin
                    srcReg <= adcSample;
                end
                dacSrcBit: begin
                    srcReg <= bitValue ? BIT_HIGH : BIT_LOW;
                end
                default: begin
                    srcReg <= '0;       // Zero and unused code
                end
            endcase

            // Back to offset binary, top ADC_W bits of the sample
            dacData <= {
                ~srcReg[`SAMPLE_W-1],
                srcReg[`SAMPLE_W-2 -: `ADC_W-1]
            };
        end
    end

endmodule

// File: filelist.f
+incdir+.
stcDemodPkg.sv
regBus.sv
controlRegs.sv
adcReclock.sv
bitSync.sv
dacOutput.sv
stcDemodTop.sv
tbStcDemodTop.sv

// File: regBus.sv
`timescale 1ns/1ps

module regBus import stcDemodPkg::*; (
    input  logic     clk,
    input  logic     rstN,

    // Host side, four-phase handshake
    input  logic     req,
    input  logic     wr,
    input  regAddr_t addr,
    input  regData_t wrData,
    input  byteEn_t  byteEn,
    output logic     ack,
    output regData_t rdData,

    // Register file side
    output logic     regWr,
    output regAddr_t regAddr,
    output regData_t regWrData,
    output byteEn_t  regByteEn,
    input  regData_t regRdData
);

    typedef enum logic [1:0] {
        stIdle,
        stAccess,       // Register access cycle
        stDone,
        stRelease       // Ack high, waiting for req to drop
    } busState_t;

    busState_t state;
    logic      accept;

    assign accept = (state == stIdle) && req;

    //*********************************************************************
    // Handshake FSM
    //*********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            ack   <= 1'b0;
            regWr <= 1'b0;
        end else begin
            regWr <= 1'b0;                  // Strobe lasts one cycle
            case (state)
                stIdle: begin
                    if (req) begin
                        regWr <= wr;
                        state <= stAccess;
                    end
                end
                stAccess: begin
                    state <= stDone;
                end
                stDone: begin
                    ack   <= 1'b1;          // Two cycles after req seen
                    state <= stRelease;
                end
                stRelease: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Request fields held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            regAddr   <= addr;
            regWrData <= wrData;
            regByteEn <= byteEn;
        end
        // Read data captured in the access cycle, held until next read
        if (state == stAccess && !regWr) begin
            rdData <= regRdData;
        end
    end

endmodule

// File: stcDemodPkg.sv
`include "stcDemod_cfg.svh"

package stcDemodPkg;

    // Raw converter word, offset binary
    typedef logic [`ADC_W-1:0] adcWord_t;

    // Internal two's complement sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    //*********************************************************************
    // Register port
    //*********************************************************************
    typedef logic [`REG_ADDR_W-1:0]   regAddr_t;
    typedef logic [`REG_DATA_W-1:0]   regData_t;
    typedef logic [`REG_DATA_W/8-1:0] byteEn_t;     // One per byte lane

    typedef logic [`CPB_W-1:0] clocksPerBit_t;

    // DAC source select, code 3 is unused and outputs zero
    typedef enum logic [1:0] {
        dacSrcAdc  = 2'd0,
        dacSrcBit  = 2'd1,
        dacSrcZero = 2'd2
    } dacSource_t;

endpackage

// File: stcDemodTop.sv
`timescale 1ns/1ps

module stcDemodTop import stcDemodPkg::*; (
    input  logic     clk,
    input  logic     rstN,

    // Host register port
    input  logic     req,
    input  logic     wr,
    input  regAddr_t addr,
    input  regData_t wrData,
    input  byteEn_t  byteEn,
    output logic     ack,
    output regData_t rdData,

    input  adcWord_t adc,
    output adcWord_t dac0Data,
    output adcWord_t dac1Data,

    // Channel clock and data pins
    output logic     chClkOut,
    output logic     chDataOut
);

    logic          regWr;
    regAddr_t      regAddr;
    regData_t      regWrData;
    byteEn_t       regByteEn;
    regData_t      regRdData;
    clocksPerBit_t clocksPerBit;
    dacSource_t    dac0Source;
    dacSource_t    dac1Source;
    sample_t       adcSample;
    logic          bitValue;

    //*********************************************************************
    // Bus interface
    //*********************************************************************
    regBus regBus_i (
        .clk(clk),
        .rstN(rstN),
        .req(req),
        .wr(wr),
        .addr(addr),
        .wrData(wrData),
        .byteEn(byteEn),
        .ack(ack),
        .rdData(rdData),
        .regWr(regWr),
        .regAddr(regAddr),
        .regWrData(regWrData),
        .regByteEn(regByteEn),
        .regRdData(regRdData)
    );

    //*********************************************************************
    // Registers
    //*********************************************************************
    controlRegs controlRegs_i (
        .clk(clk),
        .rstN(rstN),
        .regWr(regWr),
        .regAddr(regAddr),
        .regWrData(regWrData),
        .regByteEn(regByteEn),
        .regRdData(regRdData),
        .clocksPerBit(clocksPerBit),
        .dac0Source(dac0Source),
        .dac1Source(dac1Source)
    );

    //*********************************************************************
    // ADC reclock and bit output
    //*********************************************************************
    adcReclock adcReclock_i (
        .clk(clk),
        .rstN(rstN),
        .adc(adc),
        .adcSample(adcSample)
    );

    bitSync bitSync_i (
        .clk(clk),
        .rstN(rstN),
        .clocksPerBit(clocksPerBit),
        .adcSample(adcSample),
        .bitValue(bitValue),
        .chClkOut(chClkOut),
        .chDataOut(chDataOut)
    );

    //*********************************************************************
    // DAC outputs
    //*********************************************************************
    dacOutput dacOutput0_i (
        .clk(clk),
        .rstN(rstN),
        .dacSource(dac0Source),
        .adcSample(adcSample),
        .bitValue(bitValue),
        .dacData(dac0Data)
    );

    dacOutput dacOutput1_i (
        .clk(clk),
        .rstN(rstN),
        .dacSource(dac1Source),
        .adcSample(adcSample),
        .bitValue(bitValue),
        .dacData(dac1Data)
    );

endmodule

// File: stcDemod_cfg.svh
`ifndef STCDEMOD_CFG_SVH
`define STCDEMOD_CFG_SVH

// Datapath widths
`define ADC_W       14          // ADC and DAC word
`define SAMPLE_W    18          // Internal signed sample

// Register port
`define REG_ADDR_W  8
`define REG_DATA_W  32

`define VER_NUMBER  530

//*********************************************************************
// Register map
//*********************************************************************
`define VERSION_ADDR        8'h00   // Read only
`define SCRATCH_ADDR        8'h04
`define CLOCKS_PER_BIT_ADDR 8'h10
`define DAC_SELECT_ADDR     8'h14

// Bit rate control
`define CPB_RESET   16
`define CPB_W       16

`endif

// File: stcDemod_testdata.txt
# write addr data byteEn | read addr expected | all fields hex
# adc value expDac0 expDac1 (hex) | period clocksPerBit (decimal)
read 10 00000010
read 14 00000000
read 04 00000000
read 00 00000212
write 04 ffffffff 5
read 04 00ff00ff
read 40 00000000
write 00 12345678 f
read 00 00000212
write 40 ffffffff f
read 40 00000000
write 14 00000010 1
read 14 00000010
adc 2abc 2abc 3fff
adc 0123 0123 0000
adc 3fff 3fff 3fff
adc 2000 2000 3fff
adc 1fff 1fff 0000
period 6
period 7
adc 3456 3456 3fff
period 1
adc 0ff0 0ff0 0000
period 5
read 10 00000005

// File: tbStcDemodTop.sv
`timescale 1ns/1ps
`include "stcDemod_cfg.svh"

module tbStcDemodTop import stcDemodPkg::*; ();

    logic     clk;
    logic     rstN;
    logic     req;
    logic     wr;
    regAddr_t addr;
    regData_t wrData;
    byteEn_t  byteEn;
    logic     ack;
    regData_t rdData;
    adcWord_t adc;
    adcWord_t dac0Data;
    adcWord_t dac1Data;
    logic     chClkOut;
    logic     chDataOut;

    int       mismatchCount = 0;
    int       failCount     = 0;
    int       lineCount     = 0;
    logic     linesCounted  = 1'b0;
    adcWord_t heldAdc;          // Last value put on the ADC pins
    int       curCpb;           // Last clocks-per-bit written

    stcDemodTop stcDemodTop_i (
        .clk(clk), .rstN(rstN),
        .req(req), .wr(wr), .addr(addr), .wrData(wrData), .byteEn(byteEn),
        .ack(ack), .rdData(rdData),
        .adc(adc), .dac0Data(dac0Data), .dac1Data(dac1Data),
        .chClkOut(chClkOut), .chDataOut(chDataOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int effPeriod(input int n);
        return (n < 2) ? 2 : n;     // Short periods clamp to 2
    endfunction

    task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatchCount++;
        end
    endtask

    task automatic printCounts();
        $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failCount);
    endtask

    //*********************************************************************
    // Four-phase register access
    //*********************************************************************
    task automatic busAccess(
        input  logic     isWrite,
        input  regAddr_t a,
        input  regData_t d,
        input  byteEn_t  be,
        output regData_t rd
    );
        int waitCyc;
        rd = '0;
        @(posedge clk);
        wr     <= isWrite;
        addr   <= a;
        wrData <= d;
        byteEn <= be;
        @(posedge clk);
        req <= 1'b1;                // Fields already stable
        waitCyc = 0;
        while (ack !== 1'b1 && waitCyc < 20) begin
            @(negedge clk);
            waitCyc++;
        end
        if (ack !== 1'b1) begin
            $display("Handshake timeout at %0t: ack never rose for address %h", $time, a);
            failCount++;
        end else if (waitCyc > 4) begin
            // ack due two edges after req is sampled
            $display("Handshake error at %0t: ack rose %0d cycles after req", $time, waitCyc);
            failCount++;
        end
        rd = rdData;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        if (ack !== 1'b1) begin
            $display("Handshake error at %0t: ack fell before req was dropped", $time);
            failCount++;
        end
        waitCyc = 0;
        while (ack !== 1'b0 && waitCyc < 20) begin
            @(negedge clk);
            waitCyc++;
        end
        if (ack !== 1'b0) begin
            $display("Handshake timeout at %0t: ack stayed high after req dropped", $time);
            failCount++;
        end
    endtask

    // Hold an ADC value until both DAC paths have settled
    task automatic checkAdc(input adcWord_t v, input adcWord_t exp0, input adcWord_t exp1);
        @(posedge clk);
        adc <= v;
        heldAdc = v;
        repeat (effPeriod(curCpb) + 8) @(posedge clk);
        @(negedge clk);
        expectEq("dac0Data", 32'(exp0), 32'(dac0Data));
        expectEq("dac1Data", 32'(exp1), 32'(dac1Data));
    endtask

    //*********************************************************************
    // Channel clock period, high time and data bit
    //*********************************************************************
    task automatic checkBitTiming(input int n);
        int   eff;
        int   rises;
        int   cyc;
        int   startCyc;
        int   highCyc;
        logic prevClk;
        eff      = effPeriod(n);
        rises    = 0;
        cyc      = 0;
        startCyc = 0;
        highCyc  = 0;
        prevClk  = chClkOut;
        while (rises < 4 && cyc < 4 * eff + 50) begin
            @(negedge clk);
            cyc++;
            if (chClkOut && !prevClk) begin
                rises++;
                if (rises == 4) begin   // Earlier periods may still use the old rate
                    expectEq("chClkOut period", eff, cyc - startCyc);
                    expectEq("chClkOut high time", (eff + 1) / 2, highCyc);
                end
                if (rises >= 2) begin
                    expectEq("chDataOut", 32'(heldAdc[`ADC_W-1]), 32'(chDataOut));
                end
                startCyc = cyc;
                highCyc  = 0;
            end
            if (chClkOut) highCyc++;
            prevClk = chClkOut;
        end
        if (rises < 4) begin
            $display("Channel clock stopped at %0t with clocksPerBit %0d", $time, n);
            failCount++;
        end
    endtask

    // ack must only rise while req is high
    initial begin : ackMonitor
        logic prevAck;
        prevAck = 1'b0;
        forever begin
            @(negedge clk);
            if (ack && !prevAck && !req) begin
                $display("Handshake error at %0t: ack rose without req", $time);
                failCount++;
            end
            prevAck = ack;
        end
    end

    initial begin : watchdog
        wait (linesCounted);
        repeat (300 * (lineCount + 1)) @(posedge clk);
        $display("Watchdog expired at %0t, the test did not finish", $time);
        failCount++;
        printCounts();
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : mainSeq
        int              fd;
        int              code;
        int              n;
        logic            eof;
        logic [8*16-1:0] cmd;
        logic [8*200-1:0] lineBuf;
        regAddr_t        a;
        regData_t        d;
        regData_t        rd;
        byteEn_t         be;
        adcWord_t        v;
        adcWord_t        e0;
        adcWord_t        e1;

        rstN   <= 1'b0;
        req    <= 1'b0;
        wr     <= 1'b0;
        addr   <= '0;
        wrData <= '0;
        byteEn <= '0;
        adc    <= '0;
        heldAdc = '0;
        curCpb  = `CPB_RESET;

        fd = $fopen("stcDemod_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open stcDemod_testdata.txt");
            failCount++;
        end else begin
            while ($fgets(lineBuf, fd) != 0) lineCount++;
            $fclose(fd);
            fd = $fopen("stcDemod_testdata.txt", "r");
        end
        linesCounted = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        expectEq("ack", 0, 32'(ack));
        expectEq("chClkOut", 0, 32'(chClkOut));
        expectEq("chDataOut", 0, 32'(chDataOut));
        expectEq("dac0Data", 0, 32'(dac0Data));
        expectEq("dac1Data", 0, 32'(dac1Data));
        @(posedge clk);
        rstN <= 1'b1;

        eof = (fd == 0);
        while (!eof) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                eof = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(lineBuf, fd);     // Skip comment text
            end else if (cmd == "write") begin
                code = $fscanf(fd, "%h %h %h", a, d, be);
                busAccess(1'b1, a, d, be, rd);
                if (a == `CLOCKS_PER_BIT_ADDR) curCpb = int'(d[`CPB_W-1:0]);
            end else if (cmd == "read") begin
                code = $fscanf(fd, "%h %h", a, d);
                busAccess(1'b0, a, '0, '0, rd);
                expectEq("rdData", d, rd);
            end else if (cmd == "adc") begin
                code = $fscanf(fd, "%h %h %h", v, e0, e1);
                checkAdc(v, e0, e1);
            end else if (cmd == "period") begin
                code = $fscanf(fd, "%d", n);
                busAccess(1'b1, `CLOCKS_PER_BIT_ADDR, regData_t'(n), 4'hf, rd);
                curCpb = n;
                checkBitTiming(n);
            end else begin
                $display("Unknown command %0s in stcDemod_testdata.txt", cmd);
                failCount++;
            end
        end
        if (fd != 0) $fclose(fd);

        printCounts();
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
